// ==== hw/sd_pkg.sv ====
package sd_pkg;

    localparam int cmd_body_w  = 40;
    localparam int crc_w       = 7;
    localparam int crc_work_w  = cmd_body_w + crc_w;
    localparam int cmd_frame_w = cmd_body_w + crc_w + 1;

    // x^7 + x^3 + 1 with the implicit top term written out.
    localparam logic [7:0] crc7_poly = 8'h89;

    typedef logic [cmd_body_w-1:0]  cmd_body_t;
    typedef logic [cmd_frame_w-1:0] cmd_frame_t;
    typedef logic [31:0]            cmd_arg_t;
    typedef logic [5:0]             cmd_index_t;
    typedef logic [crc_w-1:0]       crc7_t;
    typedef logic [7:0]             clk_div_t;

    typedef logic [3:0]             wb_addr_t;
    typedef logic [31:0]            wb_data_t;

    localparam wb_addr_t reg_arg_addr    = 4'h0;
    localparam wb_addr_t reg_cmd_addr    = 4'h4;
    localparam wb_addr_t reg_status_addr = 4'h8;
    localparam wb_addr_t reg_div_addr    = 4'hC;

    typedef enum logic [1:0] {
        crc_idle,
        crc_working,
        crc_valid
    } crc_state_t;

    typedef enum logic [1:0] {
        ser_idle,
        ser_crc_wait,
        ser_shifting
    } ser_state_t;

endpackage

// ==== hw/sd_crc7.sv ====
`timescale 1ns/1ps

module sd_crc7 import sd_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       load,
    input  cmd_body_t  data_in,

    output crc7_t      crc_out,
    output logic       valid
);

    localparam logic [crc_work_w-1:0] poly_start = {crc7_poly, {(crc_work_w-8){1'b0}}};

    logic [crc_work_w-1:0] work;
    logic [crc_work_w-1:0] work_next;
    logic [crc_work_w-1:0] polyshift;
    crc_state_t            state;
    crc_state_t            state_next;
    logic [5:0]            count;
    logic [5:0]            count_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            work      <= '0;
            polyshift <= poly_start;
            state     <= crc_idle;
            count     <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
            if (load) begin
                work <= {data_in, {crc_w{1'b0}}};   // body followed by seven zero bits.
            end else begin
                work <= work_next;
            end

            if (state == crc_working) begin
                polyshift <= polyshift >> 1;
            end else if (state == crc_valid) begin
                polyshift <= poly_start;    // realign for the next load.
            end
        end
    end

    always_comb begin
        state_next = state;
        count_next = count;

        case (state)
            crc_idle, crc_valid: begin
                if (load) begin
                    state_next = crc_working;
                    count_next = '0;
                end
            end

            crc_working: begin
                if (count == 6'(cmd_body_w - 1)) begin
                    state_next = crc_valid;
                    count_next = '0;
                end else begin
                    count_next = count + 6'd1;
                end
            end

            default: begin
                state_next = crc_idle;
            end
        endcase
    end

    always_comb begin
        work_next = work;
        crc_out   = '0;
        valid     = 1'b0;

        case (state)
            crc_working: begin
                // the polynomial sits under the current leading bit.
                if (work[6'(crc_work_w - 1) - count]) begin
                    work_next = work ^ polyshift;
                end
            end

            crc_valid: begin
                crc_out = work[crc_w-1:0];
                valid   = ~load;    // a new load drops valid at once.
            end

            default: begin
                work_next = work;
            end
        endcase
    end

endmodule

// ==== hw/sd_cmd_regs.sv ====
`timescale 1ns/1ps

module sd_cmd_regs import sd_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack,

    input  logic       busy,
    input  logic       frame_done,
    output logic       start,
    output cmd_index_t cmd_index,
    output cmd_arg_t   cmd_arg,
    output clk_div_t   clk_div
);

    logic     req;
    logic     wr;
    logic     accept_cmd;
    logic     done;
    wb_data_t rd_data;

    // ack low on the cycle after ack keeps a held request from being taken twice.
    assign req = wb_cyc & wb_stb & ~wb_ack;
    assign wr  = req & wb_we;

    assign accept_cmd = wr & (wb_adr == reg_cmd_addr) & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            start   <= 1'b0;
            done    <= 1'b0;
            clk_div <= '0;
        end else begin
            wb_ack <= req;
            start  <= accept_cmd;

            if (accept_cmd) begin
                done <= 1'b0;   // cleared by the next accepted command.
            end else if (frame_done) begin
                done <= 1'b1;
            end

            if (wr && wb_adr == reg_div_addr) begin
                clk_div <= wb_dat_w[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && wb_adr == reg_arg_addr) begin
            cmd_arg <= wb_dat_w;
        end

        if (accept_cmd) begin
            cmd_index <= wb_dat_w[5:0];
        end

        if (req && !wb_we) begin
            wb_dat_r <= rd_data;    // held for the ack cycle.
        end
    end

    always_comb begin
        rd_data = '0;

        case (wb_adr)
            reg_arg_addr: begin
                rd_data = cmd_arg;
            end

            reg_cmd_addr: begin
                rd_data = {26'd0, cmd_index};
            end

            reg_status_addr: begin
                rd_data = {30'd0, done, busy};
            end

            reg_div_addr: begin
                rd_data = {24'd0, clk_div};
            end

            default: begin
                rd_data = '0;   // unknown offsets read zero.
            end
        endcase
    end

endmodule

// ==== hw/sd_cmd_serializer.sv ====
`timescale 1ns/1ps

module sd_cmd_serializer import sd_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       start,
    input  cmd_index_t cmd_index,
    input  cmd_arg_t   cmd_arg,
    input  clk_div_t   clk_div,
    output logic       busy,
    output logic       frame_done,

    output logic       sd_clk,
    output logic       cmd,
    output logic       cmd_oe
);

    ser_state_t state;
    cmd_body_t  body;
    cmd_frame_t shreg;
    clk_div_t   div_q;
    clk_div_t   div_cnt;
    logic [5:0] bit_cnt;
    logic       phase;
    logic       half_end;
    logic       load;
    logic       crc_valid;
    crc7_t      crc;

    sd_crc7 crc0 (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .data_in (body),
        .crc_out (crc),
        .valid   (crc_valid)
    );

    assign half_end = (div_cnt == div_q);

    assign busy   = (state != ser_idle);
    assign cmd_oe = (state == ser_shifting);
    assign sd_clk = cmd_oe & phase;     // low half first, then high half.
    assign cmd    = cmd_oe ? shreg[cmd_frame_w-1] : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ser_idle;
            load       <= 1'b0;
            frame_done <= 1'b0;
            phase      <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
        end else begin
            load       <= 1'b0;
            frame_done <= 1'b0;

            case (state)
                ser_idle: begin
                    if (start) begin
                        state <= ser_crc_wait;
                        load  <= 1'b1;
                    end
                end

                ser_crc_wait: begin
                    if (crc_valid) begin
                        state   <= ser_shifting;
                        phase   <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end

                ser_shifting: begin
                    if (half_end) begin
                        div_cnt <= '0;
                        phase   <= ~phase;
                        if (phase) begin    // end of a whole bit.
                            if (bit_cnt == 6'(cmd_frame_w - 1)) begin
                                state      <= ser_idle;
                                frame_done <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 6'd1;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end

                default: begin
                    state <= ser_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ser_idle && start) begin
            body  <= {1'b0, 1'b1, cmd_index, cmd_arg};
            div_q <= clk_div;   // the divider is fixed for the whole frame.
        end

        if (state == ser_crc_wait && crc_valid) begin
            shreg <= {body, crc, 1'b1};
        end else if (state == ser_shifting && half_end && phase) begin
            shreg <= shreg << 1;    // next bit appears as sd_clk falls.
        end
    end

endmodule

// ==== hw/sd_cmd_top.sv ====
`timescale 1ns/1ps

module sd_cmd_top import sd_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,

    output logic     sd_clk,
    output logic     cmd,
    output logic     cmd_oe
);

    logic       start;
    logic       busy;
    logic       frame_done;
    cmd_index_t cmd_index;
    cmd_arg_t   cmd_arg;
    clk_div_t   clk_div;

    sd_cmd_regs regs0 (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .busy       (busy),
        .frame_done (frame_done),
        .start      (start),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .clk_div    (clk_div)
    );

    sd_cmd_serializer ser0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .clk_div    (clk_div),
        .busy       (busy),
        .frame_done (frame_done),
        .sd_clk     (sd_clk),
        .cmd        (cmd),
        .cmd_oe     (cmd_oe)
    );

endmodule

// ==== dv/sd_cmd_assertions.sv ====
`timescale 1ns/1ps

module sd_cmd_assertions (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic sd_clk,
    input logic cmd,
    input logic cmd_oe
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wishbone ack stayed high for two cycles");

    ack_after_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wishbone ack came without a request");

    cmd_idle_high: assert property (@(posedge clk) disable iff (rst)
        !cmd_oe |-> cmd)
        else $error("cmd is not high while the line is not driven");

    // cmd may only move when sd_clk falls.
    cmd_stable_high: assert property (@(posedge clk) disable iff (rst)
        sd_clk |-> $stable(cmd))
        else $error("cmd changed while sd_clk was high");

endmodule

bind sd_cmd_top sd_cmd_assertions assertions0 (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .sd_clk (sd_clk),
    .cmd    (cmd),
    .cmd_oe (cmd_oe)
);

// ==== dv/sd_cmd_tb.sv ====
`timescale 1ns/1ps

module sd_cmd_tb import sd_pkg::*; ();

    localparam int clk_period     = 20;
    localparam int timeout_cycles = 600000;   // about twenty frames at the largest divider.

    logic     clk;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     sd_clk;
    logic     cmd;
    logic     cmd_oe;

    integer   seed;
    int       cycles = 0;
    int       errors = 0;
    int       errors_at_start = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       frames_seen = 0;
    int       frames_expected = 0;
    int       exp_period = 2;
    logic     have_rise = 1'b0;
    time      last_rise = 0;
    logic     bits[$];

    sd_cmd_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sd_clk   (sd_clk),
        .cmd      (cmd),
        .cmd_oe   (cmd_oe)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // the card samples cmd on the rising edge of sd_clk.
    always @(posedge sd_clk) begin
        if (cmd_oe) begin
            bits.push_back(cmd);
            if (have_rise) begin
                check("sd_clk period", (($time - last_rise) / clk_period), exp_period);
            end
            have_rise = 1'b1;
            last_rise = $time;
        end
    end

    always @(negedge cmd_oe) begin
        frames_seen = frames_seen + 1;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_reg(input wb_addr_t adr, output wb_data_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_dat_r;    // valid while ack is high.
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // shift register form of x^7 + x^3 + 1, one body bit per step.
    function automatic crc7_t crc7_model(input cmd_body_t body);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = cmd_body_w - 1; i >= 0; i--) begin
            fb = body[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ crc7_poly[6:0];
            end
        end
        return c;
    endfunction

    task automatic start_frame(input cmd_index_t idx, input cmd_arg_t arg, input clk_div_t div);
        write_reg(reg_arg_addr, arg);
        write_reg(reg_div_addr, {24'd0, div});
        exp_period = 2 * (int'(div) + 1);
        have_rise  = 1'b0;
        bits.delete();
        frames_expected = frames_expected + 1;
        write_reg(reg_cmd_addr, {26'd0, idx});
    endtask

    task automatic wait_frame();
        @(negedge clk);
        while (frames_seen < frames_expected) @(negedge clk);
    endtask

    task automatic compare_frame(input cmd_index_t idx, input cmd_arg_t arg);
        cmd_body_t  body;
        cmd_frame_t exp;
        cmd_frame_t got;
        crc7_t      crc;
        body = {1'b0, 1'b1, idx, arg};
        crc  = crc7_model(body);
        exp  = {body, crc, 1'b1};
        got  = '0;
        check("frame bit count", bits.size(), cmd_frame_w);
        if (bits.size() == cmd_frame_w) begin
            foreach (bits[i]) got = {got[cmd_frame_w-2:0], bits[i]};
            check("cmd frame", got, exp);
            check("start and transmission bits", got[47:46], 2'b01);
            check("frame crc", got[7:1], crc);
            check("end bit", got[0], 1'b1);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (errors == errors_at_start) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: fail, %0d mismatches", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        wb_data_t   rd;
        logic [31:0] r;
        cmd_index_t idx;
        cmd_arg_t   arg;
        clk_div_t   div;
        seed     = 33;
        rst      <= 1'b1;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        frames_seen = 0;    // drops the x to 0 edge of cmd_oe in reset.
        bits.delete();

        check("model crc of cmd0", crc7_model(40'h40_0000_0000), 7'h4a);
        check("cmd_oe", cmd_oe, 1'b0);
        check("sd_clk", sd_clk, 1'b0);
        check("cmd", cmd, 1'b1);
        check("wb_ack", wb_ack, 1'b0);
        read_reg(reg_status_addr, rd);
        check("status", rd, 32'd0);
        arg = $random(seed);
        write_reg(reg_arg_addr, arg);
        read_reg(reg_arg_addr, rd);
        check("arg register", rd, arg);
        r = $random(seed);
        write_reg(reg_div_addr, r);
        read_reg(reg_div_addr, rd);
        check("div register", rd, {24'd0, r[7:0]});
        finish_test("reset state and registers");

        for (int n = 0; n < 20; n++) begin
            r   = $random(seed);
            idx = r[5:0];
            arg = $random(seed);
            start_frame(idx, arg, 8'd0);
            wait_frame();
            compare_frame(idx, arg);
        end
        finish_test("random frames at divider 0");

        for (int n = 0; n < 6; n++) begin
            r   = $random(seed);
            idx = r[5:0];
            div = {5'd0, r[10:8]};
            arg = $random(seed);
            start_frame(idx, arg, div);
            wait_frame();
            compare_frame(idx, arg);
        end
        finish_test("random dividers");

        r   = $random(seed);
        idx = r[5:0];
        arg = $random(seed);
        start_frame(idx, arg, 8'd3);
        read_reg(reg_status_addr, rd);
        check("status busy", rd[0], 1'b1);
        write_reg(reg_cmd_addr, {26'd0, ~idx});  // must be dropped while busy.
        read_reg(reg_cmd_addr, rd);
        check("cmd readback", rd, {26'd0, idx});
        wait_frame();
        compare_frame(idx, arg);
        repeat (600) @(negedge clk);    // a second frame at divider 3 would end within this.
        check("frames sent", frames_seen, frames_expected);
        finish_test("command write while busy");

        read_reg(reg_status_addr, rd);
        check("status after frame", rd, 32'h2);
        r   = $random(seed);
        idx = r[5:0];
        arg = $random(seed);
        start_frame(idx, arg, 8'd1);
        read_reg(reg_status_addr, rd);
        check("status after new command", rd, 32'h1);
        wait_frame();
        compare_frame(idx, arg);
        read_reg(reg_status_addr, rd);
        check("status at end", rd, 32'h2);
        finish_test("done flag");

        $display("%0d tests run, %0d failed, %0d mismatches in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/sd_pkg.sv
hw/sd_crc7.sv
hw/sd_cmd_regs.sv
hw/sd_cmd_serializer.sv
hw/sd_cmd_top.sv
dv/sd_cmd_assertions.sv
dv/sd_cmd_tb.sv
